//--- filelist.f
+incdir+include
hdl/pipelinePkg.sv
hdl/programCounter.sv
hdl/hazardDetector.sv
hdl/stageTracker.sv
hdl/frontEndSequencer.sv
hdl/eventCounter.sv
hdl/hazardFrontEnd.sv
testbench/hazardFrontEnd_properties.sv
testbench/hazardFrontEnd_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the hazard front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module hazardFrontEnd_tb -o simHazard -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/simHazard 2>&1)
simStatus=$?
printf '%s\n' "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOutput" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- testbench/hazardFrontEnd_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazard_params.svh"

module hazardFrontEnd_tb;

    localparam int CLOCK_PERIOD = 8;
    // Cycle budget for one program run
    localparam int RUN_LIMIT    = 40;

    logic                     clock;
    logic                     reset;
    logic                     branchTaken;
    logic [`WORD_WIDTH-1:0]   jrTarget;
    logic [`WORD_WIDTH-1:0]   fetchAddress;
    logic [`WORD_WIDTH-1:0]   fetchInstruction;
    pipelinePkg::fetchWord_t  issue;
    pipelinePkg::perfCounts_t perf;

    // Instruction memory, 256 words, word addressed
    logic [`WORD_WIDTH-1:0] progMem [256];
    logic [15:0]            lfsrState;

    // Observed issue trace
    logic [`WORD_WIDTH-1:0] issuedPc [$];
    logic [`WORD_WIDTH-1:0] issuedInstr [$];
    int                     issuedGap [$];
    // Expected trace, gap is bubbles before each word
    logic [`WORD_WIDTH-1:0] expPc [$];
    int                     expGap [$];

    assign fetchInstruction = progMem[fetchAddress[9:2]];

    hazardFrontEnd UUT (
        .clock            (clock),
        .reset            (reset),
        .fetchInstruction (fetchInstruction),
        .branchTaken      (branchTaken),
        .jrTarget         (jrTarget),
        .fetchAddress     (fetchAddress),
        .issue            (issue),
        .perf             (perf)
    );

    bind frontEndSequencer hazardFrontEnd_properties sequencerChecks (
        .clock       (clock),
        .reset       (reset),
        .hazardCtrl  (hazardCtrl),
        .issueEnable (issueEnable),
        .state       (state)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    ////////////////////
    // Reporting

    task automatic abortRun();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            abortRun();
        end
    endtask

    ////////////////////
    // Stimulus helpers

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic randomReg(output logic [4:0] r);
        r = '0;
        for (int b = 0; b < 5; b++) begin
            lfsrState = lfsrNext(lfsrState);
            r = {r[3:0], lfsrState[0]};
        end
    endtask

    function automatic logic [31:0] encAdd(input logic [4:0] rd, input logic [4:0] rs,
                                           input logic [4:0] rt);
        return {`OPCODE_RTYPE, rs, rt, rd, 5'd0, 6'h20};
    endfunction

    function automatic logic [31:0] encLw(input logic [4:0] rt, input logic [4:0] base,
                                          input logic [15:0] offset);
        return {`OPCODE_LW, base, rt, offset};
    endfunction

    function automatic logic [31:0] encBeq(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [15:0] offset);
        return {`OPCODE_BEQ, rs, rt, offset};
    endfunction

    function automatic logic [31:0] encJr(input logic [4:0] rs);
        return {`OPCODE_RTYPE, rs, 15'd0, `FUNCT_JR};
    endfunction

    // Filler reads and writes nothing, immediate is the word index
    task automatic fillMemory();
        logic [7:0] idx;
        for (int i = 0; i < 256; i++) begin
            idx = 8'(i);
            progMem[idx] = {6'b001111, 10'd0, 8'h00, idx};
        end
    endtask

    task automatic expectIssue(input logic [31:0] pc, input int gap);
        expPc.push_back(pc);
        expGap.push_back(gap);
    endtask

    // Reset held while the program is written in the same step
    task automatic beginReset(input logic taken, input logic [31:0] target);
        @(posedge clock);
        #1;
        reset       = 1'b1;
        branchTaken = taken;
        jrTarget    = target;
        fillMemory();
        expPc.delete();
        expGap.delete();
    endtask

    task automatic endReset();
        repeat (3) @(posedge clock);
        #1;
        // Reset state before release
        checkValue("fetchAddress", fetchAddress, 32'd0);
        checkValue("issue.valid", 32'(issue.valid), 32'd0);
        checkCounts(0, 0, 0);
        reset = 1'b0;
    endtask

    ////////////////////
    // Trace capture and checks

    task automatic collectIssues();
        int gap;
        int cycles;
        issuedPc.delete();
        issuedInstr.delete();
        issuedGap.delete();
        gap    = 0;
        cycles = 0;
        while (issuedPc.size() < expPc.size()) begin
            if (cycles == RUN_LIMIT) begin
                $display("Timeout: only %0d of %0d instructions issued in %0d cycles",
                         issuedPc.size(), expPc.size(), RUN_LIMIT);
                abortRun();
            end
            // Mid-cycle, outputs settled
            @(negedge clock);
            cycles++;
            if (issue.valid) begin
                issuedPc.push_back(issue.pc);
                issuedInstr.push_back(issue.instruction);
                issuedGap.push_back(gap);
                gap = 0;
            end else begin
                gap++;
            end
        end
    endtask

    task automatic checkTrace();
        int i;
        for (i = 0; i < expPc.size(); i++) begin
            checkValue($sformatf("issue.pc[%0d]", i), issuedPc[i], expPc[i]);
            checkValue($sformatf("issue.instruction[%0d]", i), issuedInstr[i],
                       progMem[expPc[i][9:2]]);
            // First word's lead-in includes boot, not a hazard
            if (i > 0) begin
                checkValue($sformatf("bubbles before issue %0d", i), 32'(issuedGap[i]),
                           32'(expGap[i]));
            end
        end
    endtask

    task automatic checkNotIssued(input logic [31:0] pc);
        int i;
        for (i = 0; i < issuedPc.size(); i++) begin
            if (issuedPc[i] == pc) begin
                $display("Wrong-path word at pc 0x%08h was issued", pc);
                abortRun();
            end
        end
    endtask

    task automatic checkCounts(input int stalls, input int loadStalls, input int redirects);
        checkValue("perf.stallCycles", 32'(perf.stallCycles), 32'(stalls));
        checkValue("perf.loadStallCycles", 32'(perf.loadStallCycles), 32'(loadStalls));
        checkValue("perf.redirects", 32'(perf.redirects), 32'(redirects));
    endtask

    ////////////////////
    // Directed tests

    // No shared registers, straight-line flow
    task automatic testIndependent();
        logic [4:0] dest [$];
        logic [4:0] r;
        bit         fresh;
        beginReset(1'b0, '0);
        while (dest.size() < 6) begin
            randomReg(r);
            fresh = (r != 5'd0);
            foreach (dest[k]) begin
                if (dest[k] == r) begin
                    fresh = 1'b0;
                end
            end
            if (fresh) begin
                progMem[dest.size()] = encAdd(r, 5'd0, 5'd0);
                expectIssue(32'(dest.size() * 4), 0);
                dest.push_back(r);
            end
        end
        endReset();
        collectIssues();
        checkTrace();
        checkCounts(0, 0, 0);
    endtask

    task automatic testAluDistance();
        beginReset(1'b0, '0);
        progMem[0] = encAdd(5'd5, 5'd0, 5'd0);
        progMem[1] = encAdd(5'd6, 5'd5, 5'd0);
        progMem[2] = encAdd(5'd7, 5'd0, 5'd0);
        progMem[3] = encAdd(5'd8, 5'd0, 5'd0);
        progMem[4] = encAdd(5'd9, 5'd0, 5'd7);
        progMem[5] = encAdd(5'd10, 5'd0, 5'd0);
        progMem[6] = encAdd(5'd11, 5'd0, 5'd0);
        progMem[7] = encAdd(5'd12, 5'd0, 5'd0);
        progMem[8] = encAdd(5'd13, 5'd10, 5'd0);
        // Adjacent 2, one between 1, two between 0
        expectIssue(32'd0, 0);
        expectIssue(32'd4, 2);
        expectIssue(32'd8, 0);
        expectIssue(32'd12, 0);
        expectIssue(32'd16, 1);
        expectIssue(32'd20, 0);
        expectIssue(32'd24, 0);
        expectIssue(32'd28, 0);
        expectIssue(32'd32, 0);
        endReset();
        collectIssues();
        checkTrace();
        checkCounts(3, 0, 0);
    endtask

    task automatic testLoadUse();
        beginReset(1'b0, '0);
        progMem[0] = encLw(5'd4, 5'd0, 16'h0010);
        progMem[1] = encAdd(5'd5, 5'd4, 5'd0);
        progMem[2] = encLw(5'd6, 5'd0, 16'h0020);
        progMem[3] = encAdd(5'd8, 5'd0, 5'd0);
        progMem[4] = encAdd(5'd9, 5'd6, 5'd0);
        // Writes to r0 never count as producers
        progMem[5] = encLw(5'd0, 5'd0, 16'h0030);
        progMem[6] = encAdd(5'd10, 5'd0, 5'd0);
        progMem[7] = encAdd(5'd0, 5'd1, 5'd2);
        progMem[8] = encAdd(5'd11, 5'd0, 5'd0);
        expectIssue(32'd0, 0);
        expectIssue(32'd4, 2);
        expectIssue(32'd8, 0);
        expectIssue(32'd12, 0);
        expectIssue(32'd16, 1);
        expectIssue(32'd20, 0);
        expectIssue(32'd24, 0);
        expectIssue(32'd28, 0);
        expectIssue(32'd32, 0);
        endReset();
        collectIssues();
        checkTrace();
        checkCounts(3, 3, 0);
    endtask

    task automatic testBranch(input logic taken);
        logic [31:0] target;
        // Taken beq at pc 4 with offset 5 lands on word 7
        target = 32'd28;
        beginReset(taken, '0);
        progMem[0] = encAdd(5'd3, 5'd0, 5'd0);
        progMem[1] = encBeq(5'd3, 5'd0, 16'd5);
        // Fall-through path
        progMem[2] = encAdd(5'd20, 5'd0, 5'd0);
        progMem[3] = encAdd(5'd21, 5'd0, 5'd0);
        progMem[target[9:2]] = encAdd(5'd12, 5'd0, 5'd0);
        expectIssue(32'd0, 0);
        expectIssue(32'd4, 2);
        if (taken) begin
            // Squash slot shows as one bubble
            expectIssue(target, 1);
            expectIssue(target + 32'd4, 0);
        end else begin
            expectIssue(32'd8, 0);
            expectIssue(32'd12, 0);
        end
        endReset();
        collectIssues();
        if (taken) begin
            checkNotIssued(32'd8);
        end
        checkTrace();
        if (taken) begin
            checkCounts(2, 0, 1);
        end else begin
            checkCounts(2, 0, 0);
        end
    endtask

    task automatic testJr();
        beginReset(1'b0, 32'h0000_0040);
        progMem[0]  = encAdd(5'd31, 5'd0, 5'd0);
        progMem[1]  = encJr(5'd31);
        progMem[2]  = encAdd(5'd22, 5'd0, 5'd0);
        progMem[16] = encAdd(5'd13, 5'd0, 5'd0);
        expectIssue(32'd0, 0);
        expectIssue(32'd4, 2);
        expectIssue(32'h0000_0040, 1);
        expectIssue(32'h0000_0044, 0);
        endReset();
        collectIssues();
        checkNotIssued(32'd8);
        checkTrace();
        checkCounts(2, 0, 1);
    endtask

    ////////////////////
    // Main sequence

    initial begin
        reset       = 1'b1;
        branchTaken = 1'b0;
        jrTarget    = '0;
        lfsrState   = 16'd2;
        fillMemory();
        testIndependent();
        testAluDistance();
        testLoadUse();
        testBranch(1'b1);
        testBranch(1'b0);
        testJr();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/hazardFrontEnd_properties.sv
`timescale 1ns/1ps
`default_nettype none

module hazardFrontEnd_properties (
    input wire logic                     clock,
    input wire logic                     reset,
    input wire pipelinePkg::hazardCtrl_t hazardCtrl,
    input wire logic                     issueEnable,
    input wire pipelinePkg::seqState_e   state
);

    ////////////////////
    // Sequencer control checks

    // Detector never asks for a stall and a redirect at once
    stallRedirectExclusive: assert property (@(posedge clock) disable iff (reset)
        !(hazardCtrl.stall && hazardCtrl.redirect))
        else $error("Stall and redirect requested in the same cycle");

    // Nothing leaves decode before the first word is loaded
    bootNoIssue: assert property (@(posedge clock) disable iff (reset)
        (state == pipelinePkg::SQ_BOOT) |-> !issueEnable)
        else $error("Issue enabled in the boot state");

    // Squash slot is a single cycle, then back to normal flow
    redirectOneCycle: assert property (@(posedge clock) disable iff (reset)
        (state == pipelinePkg::SQ_REDIRECT) |=> (state == pipelinePkg::SQ_RUN))
        else $error("Redirect state lasted longer than one cycle");

endmodule

`default_nettype wire

//--- hdl/hazardFrontEnd.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazard_params.svh"

module hazardFrontEnd (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic [`WORD_WIDTH-1:0] fetchInstruction,
    input  wire logic                   branchTaken,
    input  wire logic [`WORD_WIDTH-1:0] jrTarget,
    output logic      [`WORD_WIDTH-1:0] fetchAddress,
    output pipelinePkg::fetchWord_t     issue,
    output pipelinePkg::perfCounts_t    perf
);

    ////////////////////
    // Internal wiring

    pipelinePkg::fetchWord_t  decodeWord;
    pipelinePkg::stageTag_t   exTag;
    pipelinePkg::stageTag_t   memTag;
    pipelinePkg::hazardCtrl_t hazardCtrl;

    // Sequencer strobes
    logic pcEnable;
    logic pcRedirect;
    logic decodeLoad;
    logic decodeSquash;
    logic issueEnable;

    programCounter pcReg (
        .clock          (clock),
        .reset          (reset),
        .pcEnable       (pcEnable),
        .pcRedirect     (pcRedirect),
        .redirectTarget (hazardCtrl.redirectTarget),
        .fetchAddress   (fetchAddress)
    );

    stageTracker tracker (
        .clock            (clock),
        .reset            (reset),
        .fetchInstruction (fetchInstruction),
        .fetchAddress     (fetchAddress),
        .decodeLoad       (decodeLoad),
        .decodeSquash     (decodeSquash),
        .issueEnable      (issueEnable),
        .decodeWord       (decodeWord),
        .exTag            (exTag),
        .memTag           (memTag),
        .issue            (issue)
    );

    hazardDetector detector (
        .decodeWord  (decodeWord),
        .exTag       (exTag),
        .memTag      (memTag),
        .branchTaken (branchTaken),
        .jrTarget    (jrTarget),
        .hazardCtrl  (hazardCtrl)
    );

    // State is observed by the bound checks only
    frontEndSequencer sequencer (
        .clock        (clock),
        .reset        (reset),
        .hazardCtrl   (hazardCtrl),
        .pcEnable     (pcEnable),
        .pcRedirect   (pcRedirect),
        .decodeLoad   (decodeLoad),
        .decodeSquash (decodeSquash),
        .issueEnable  (issueEnable),
        .state        ()
    );

    eventCounter counters (
        .clock      (clock),
        .reset      (reset),
        .hazardCtrl (hazardCtrl),
        .perf       (perf)
    );

endmodule

`default_nettype wire

//--- hdl/eventCounter.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazard_params.svh"

module eventCounter (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire pipelinePkg::hazardCtrl_t hazardCtrl,
    output pipelinePkg::perfCounts_t      perf
);

    localparam logic [`COUNT_WIDTH-1:0] COUNT_MAX = '1;

    logic isLoadStall;

    // Increment that sticks at the top
    function automatic logic [`COUNT_WIDTH-1:0] bump(
        input logic [`COUNT_WIDTH-1:0] value,
        input logic                    hit
    );
        if (hit && (value != COUNT_MAX)) begin
            return value + 1'b1;
        end
        return value;
    endfunction

    // Stall caused by a load in either stage
    assign isLoadStall = hazardCtrl.stall
                      && ((hazardCtrl.kind == pipelinePkg::HK_LOAD_EX)
                       || (hazardCtrl.kind == pipelinePkg::HK_LOAD_MEM));

    always_ff @(posedge clock) begin
        if (reset) begin
            perf <= '0;
        end else begin
            perf.stallCycles     <= bump(perf.stallCycles, hazardCtrl.stall);
            perf.loadStallCycles <= bump(perf.loadStallCycles, isLoadStall);
            perf.redirects       <= bump(perf.redirects, hazardCtrl.redirect);
        end
    end

endmodule

`default_nettype wire

//--- hdl/frontEndSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module frontEndSequencer (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire pipelinePkg::hazardCtrl_t hazardCtrl,
    output logic                          pcEnable,
    output logic                          pcRedirect,
    output logic                          decodeLoad,
    output logic                          decodeSquash,
    output logic                          issueEnable,
    output pipelinePkg::seqState_e        state
);

    pipelinePkg::seqState_e nextState;

    // State register
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= pipelinePkg::SQ_BOOT;
        end else begin
            state <= nextState;
        end
    end

    ////////////////////
    // Next state and strobes

    always_comb begin
        pcEnable     = 1'b0;
        pcRedirect   = 1'b0;
        decodeLoad   = 1'b0;
        decodeSquash = 1'b0;
        issueEnable  = 1'b0;
        nextState    = state;

        case (state)
            pipelinePkg::SQ_BOOT: begin
                // Decode empty, first word at address zero captured
                pcEnable   = 1'b1;
                decodeLoad = 1'b1;
                nextState  = pipelinePkg::SQ_RUN;
            end
            pipelinePkg::SQ_RUN,
            pipelinePkg::SQ_STALL: begin
                if (hazardCtrl.stall) begin
                    // Freeze pc and decode, bubble out
                    nextState = pipelinePkg::SQ_STALL;
                end else if (hazardCtrl.redirect) begin
                    // Branch or jr issues, wrong-path fetch dropped
                    pcEnable     = 1'b1;
                    pcRedirect   = 1'b1;
                    decodeLoad   = 1'b1;
                    decodeSquash = 1'b1;
                    issueEnable  = 1'b1;
                    nextState    = pipelinePkg::SQ_REDIRECT;
                end else begin
                    pcEnable    = 1'b1;
                    decodeLoad  = 1'b1;
                    issueEnable = 1'b1;
                    nextState   = pipelinePkg::SQ_RUN;
                end
            end
            pipelinePkg::SQ_REDIRECT: begin
                // Squashed slot in decode, target word fetched
                pcEnable   = 1'b1;
                decodeLoad = 1'b1;
                nextState  = pipelinePkg::SQ_RUN;
            end
            default: begin
                nextState = pipelinePkg::SQ_BOOT;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/stageTracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazard_params.svh"

module stageTracker (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic [`WORD_WIDTH-1:0] fetchInstruction,
    input  wire logic [`WORD_WIDTH-1:0] fetchAddress,
    input  wire logic                   decodeLoad,
    input  wire logic                   decodeSquash,
    input  wire logic                   issueEnable,
    output pipelinePkg::fetchWord_t     decodeWord,
    output pipelinePkg::stageTag_t      exTag,
    output pipelinePkg::stageTag_t      memTag,
    output pipelinePkg::fetchWord_t     issue
);

    // Fetch-to-decode register
    logic [`WORD_WIDTH-1:0] decodeInstr;
    logic [`WORD_WIDTH-1:0] decodePc;
    logic                   decodeValid;

    // Destination of the word now in decode
    pipelinePkg::stageTag_t issueTag;
    logic [5:0]             opcode;
    logic [5:0]             funct;

    ////////////////////
    // Decode register

    // Payload, held while stalled
    always_ff @(posedge clock) begin
        if (decodeLoad) begin
            decodeInstr <= fetchInstruction;
            decodePc    <= fetchAddress;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            decodeValid <= 1'b0;
        end else if (decodeSquash) begin
            // Wrong-path word enters as a bubble
            decodeValid <= 1'b0;
        end else if (decodeLoad) begin
            decodeValid <= 1'b1;
        end
    end

    always_comb begin
        decodeWord.instruction = decodeInstr;
        decodeWord.pc          = decodePc;
        decodeWord.valid       = decodeValid;
    end

    // Leaves decode this cycle unless stalled
    always_comb begin
        issue.instruction = decodeInstr;
        issue.pc          = decodePc;
        issue.valid       = decodeValid && issueEnable;
    end

    ////////////////////
    // Destination tags

    assign opcode = decodeInstr[31:26];
    assign funct  = decodeInstr[5:0];

    always_comb begin
        issueTag = '0;
        case (opcode)
            `OPCODE_RTYPE: begin
                // jr writes nothing
                if (funct != `FUNCT_JR) begin
                    issueTag.rd       = decodeInstr[15:11];
                    issueTag.regWrite = 1'b1;
                end
            end
            `OPCODE_LW: begin
                // Load result goes to rt
                issueTag.rd       = decodeInstr[20:16];
                issueTag.regWrite = 1'b1;
                issueTag.memRead  = 1'b1;
            end
            default: begin
                // beq and others, no destination
                issueTag = '0;
            end
        endcase
    end

    // Tags move every cycle, bubbles carry an empty tag
    always_ff @(posedge clock) begin
        if (reset) begin
            exTag  <= '0;
            memTag <= '0;
        end else begin
            exTag  <= issue.valid ? issueTag : '0;
            memTag <= exTag;
        end
    end

endmodule

`default_nettype wire

//--- hdl/hazardDetector.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazard_params.svh"

module hazardDetector (
    input  wire pipelinePkg::fetchWord_t  decodeWord,
    input  wire pipelinePkg::stageTag_t   exTag,
    input  wire pipelinePkg::stageTag_t   memTag,
    input  wire logic                     branchTaken,
    input  wire logic [`WORD_WIDTH-1:0]   jrTarget,
    output pipelinePkg::hazardCtrl_t      hazardCtrl
);

    // Instruction fields
    logic [5:0]                 opcode;
    logic [5:0]                 funct;
    logic [`REG_ADDR_WIDTH-1:0] rs;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic [15:0]                offset;

    logic                       isBeq;
    logic                       isJr;
    logic [`WORD_WIDTH-1:0]     branchTarget;

    // Producer matches per stage
    logic                       exHitsSrc;
    logic                       memHitsSrc;
    logic                       exHitsLink;
    logic                       memHitsLink;

    // True when a stage will write the given register
    // Register 0 is never a real destination
    function automatic logic writesReg(
        input pipelinePkg::stageTag_t   tag,
        input logic [`REG_ADDR_WIDTH-1:0] regNum
    );
        return tag.regWrite && (tag.rd != '0) && (tag.rd == regNum);
    endfunction

    // Stall cause from the producer's stage and kind
    function automatic pipelinePkg::hazardKind_e stallKind(
        input pipelinePkg::stageTag_t tag,
        input logic                   inEx
    );
        if (tag.memRead) begin
            return inEx ? pipelinePkg::HK_LOAD_EX : pipelinePkg::HK_LOAD_MEM;
        end
        return inEx ? pipelinePkg::HK_ALU_EX : pipelinePkg::HK_ALU_MEM;
    endfunction

    ////////////////////
    // Field decode

    assign opcode = decodeWord.instruction[31:26];
    assign rs     = decodeWord.instruction[25:21];
    assign rt     = decodeWord.instruction[20:16];
    assign funct  = decodeWord.instruction[5:0];
    assign offset = decodeWord.instruction[15:0];

    assign isBeq = (opcode == `OPCODE_BEQ);
    assign isJr  = (opcode == `OPCODE_RTYPE) && (funct == `FUNCT_JR);

    // pc + 4 + sign-extended word offset
    assign branchTarget = decodeWord.pc + `WORD_WIDTH'd4
                        + {{(`WORD_WIDTH-18){offset[15]}}, offset, 2'b00};

    // Source operand dependencies
    assign exHitsSrc  = writesReg(exTag, rs) || writesReg(exTag, rt);
    assign memHitsSrc = writesReg(memTag, rs) || writesReg(memTag, rt);

    // jr reads the link register only
    assign exHitsLink  = writesReg(exTag, `LINK_REG);
    assign memHitsLink = writesReg(memTag, `LINK_REG);

    ////////////////////
    // Prioritized decision

    always_comb begin
        hazardCtrl.stall          = 1'b0;
        hazardCtrl.redirect       = 1'b0;
        hazardCtrl.redirectTarget = isJr ? jrTarget : branchTarget;
        hazardCtrl.kind           = pipelinePkg::HK_NONE;

        // Empty or squashed decode slot takes no action
        if (decodeWord.valid) begin
            if (isBeq && memHitsSrc) begin
                // Branch operand still in flight in memory
                // Also covers a load there, both bits set
                hazardCtrl.stall = 1'b1;
                hazardCtrl.kind  = stallKind(memTag, 1'b0);
            end else if (isBeq && exHitsSrc) begin
                hazardCtrl.stall = 1'b1;
                hazardCtrl.kind  = stallKind(exTag, 1'b1);
            end else if (isBeq && branchTaken) begin
                // Operands settled, comparator says taken
                hazardCtrl.redirect = 1'b1;
                hazardCtrl.kind     = pipelinePkg::HK_BRANCH_TAKEN;
            end else if (isJr && memHitsLink) begin
                // Wait for r31 to leave the pipeline
                hazardCtrl.stall = 1'b1;
                hazardCtrl.kind  = stallKind(memTag, 1'b0);
            end else if (isJr && exHitsLink) begin
                hazardCtrl.stall = 1'b1;
                hazardCtrl.kind  = stallKind(exTag, 1'b1);
            end else if (isJr) begin
                hazardCtrl.redirect = 1'b1;
                hazardCtrl.kind     = pipelinePkg::HK_JR;
            end else if (exHitsSrc) begin
                // Plain consumer, nearest producer first
                hazardCtrl.stall = 1'b1;
                hazardCtrl.kind  = stallKind(exTag, 1'b1);
            end else if (memHitsSrc) begin
                hazardCtrl.stall = 1'b1;
                hazardCtrl.kind  = stallKind(memTag, 1'b0);
            end
            // Not-taken beq with no producer falls through
        end
    end

endmodule

`default_nettype wire

//--- hdl/programCounter.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazard_params.svh"

module programCounter (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic                   pcEnable,
    input  wire logic                   pcRedirect,
    input  wire logic [`WORD_WIDTH-1:0] redirectTarget,
    output logic      [`WORD_WIDTH-1:0] fetchAddress
);

    // Sequential fetch step, one word
    localparam logic [`WORD_WIDTH-1:0] FETCH_STEP = `WORD_WIDTH'd4;

    ////////////////////
    // Fetch address register

    always_ff @(posedge clock) begin
        if (reset) begin
            // Fetch starts at address zero
            fetchAddress <= '0;
        end else if (pcRedirect) begin
            // Taken branch or jr wins over the sequential step
            fetchAddress <= redirectTarget;
        end else if (pcEnable) begin
            fetchAddress <= fetchAddress + FETCH_STEP;
        end
        // Otherwise hold, decode is stalled
    end

endmodule

`default_nettype wire

//--- hdl/pipelinePkg.sv
`default_nettype none

`include "hazard_params.svh"

package pipelinePkg;

    // Destination of the instruction in one pipeline stage
    typedef struct packed {
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic                       regWrite;
        // Set only for loads, always together with regWrite
        logic                       memRead;
    } stageTag_t;

    // Fetch-to-decode register contents, also the issue output
    typedef struct packed {
        logic [`WORD_WIDTH-1:0] instruction;
        logic [`WORD_WIDTH-1:0] pc;
        logic                   valid;
    } fetchWord_t;

    // Cause of the current hazard decision
    typedef enum logic [2:0] {
        HK_NONE,
        HK_ALU_EX,
        HK_ALU_MEM,
        HK_LOAD_EX,
        HK_LOAD_MEM,
        HK_BRANCH_TAKEN,
        HK_JR
    } hazardKind_e;

    // Decision from the detector, at most one of stall and redirect
    typedef struct packed {
        logic                   stall;
        logic                   redirect;
        logic [`WORD_WIDTH-1:0] redirectTarget;
        hazardKind_e            kind;
    } hazardCtrl_t;

    // Sequencer states
    typedef enum logic [1:0] {
        SQ_BOOT,
        SQ_RUN,
        SQ_STALL,
        SQ_REDIRECT
    } seqState_e;

    // Performance counters
    typedef struct packed {
        logic [`COUNT_WIDTH-1:0] stallCycles;
        logic [`COUNT_WIDTH-1:0] loadStallCycles;
        logic [`COUNT_WIDTH-1:0] redirects;
    } perfCounts_t;

endpackage

`default_nettype wire

//--- include/hazard_params.svh
`ifndef HAZARD_PARAMS_SVH
`define HAZARD_PARAMS_SVH

// Datapath widths
`define WORD_WIDTH      32
`define REG_ADDR_WIDTH  5
// Per-counter width in the perf block
`define COUNT_WIDTH     16

// Primary opcodes, instruction bits 31:26
`define OPCODE_RTYPE    6'b000000
`define OPCODE_LW       6'b100011
`define OPCODE_BEQ      6'b000100

// R-type function code for jr, bits 5:0
`define FUNCT_JR        6'b001000

// Return address register read by jr
`define LINK_REG        5'd31

`endif
